// ==== logic/idu_defs.svh ====
`ifndef IDU_DEFS_SVH
`define IDU_DEFS_SVH

// data path and pc width
`define XLEN 32

// register file index
`define REG_ADDR_W 5

`define INST_W 32

`endif

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none
`include "idu_defs.svh"

package rv_isa_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    // alu funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;

    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub and sra

    typedef struct packed {
        logic [6:0]             funct7;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]            imm;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0]             imm_hi;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [4:0]             imm_lo;
        logic [6:0]             opcode;
    } s_type_t;

    typedef struct packed {
        logic                   imm12;
        logic [5:0]             imm10_5;
        logic [`REG_ADDR_W-1:0] rs2;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [2:0]             funct3;
        logic [3:0]             imm4_1;
        logic                   imm11;
        logic [6:0]             opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0]            imm;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } u_type_t;

    typedef struct packed {
        logic                   imm20;
        logic [9:0]             imm10_1;
        logic                   imm11;
        logic [7:0]             imm19_12;
        logic [`REG_ADDR_W-1:0] rd;
        logic [6:0]             opcode;
    } j_type_t;

endpackage

`default_nettype wire

// ==== logic/idu_pkg.sv ====
`default_nettype none
`include "idu_defs.svh"

package idu_pkg;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_R,
        CLS_I,
        CLS_U,
        CLS_L,
        CLS_S,
        CLS_J,
        CLS_B
    } inst_class_e;

    // add doubles as addi, the class tells them apart
    typedef enum logic [4:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_LUI, OP_AUIPC,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU
    } alu_op_e;

    typedef struct packed {
        logic                   valid;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       op1;
        logic [`XLEN-1:0]       op2;
        logic [`XLEN-1:0]       imm;
        logic [`REG_ADDR_W-1:0] rd_addr;
        logic                   rd_we;
        inst_class_e            inst_class;
        alu_op_e                alu_op;
    } dec_bundle_t;

endpackage

`default_nettype wire

// ==== logic/rf_fwd_if.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idu_defs.svh"

interface rf_fwd_if;
    logic                   ex_rd_we;
    logic [`REG_ADDR_W-1:0] ex_rd_addr;
    logic [`XLEN-1:0]       ex_rd_data;
    logic                   ex_load;    // execute holds a load, data not ready yet
    logic                   ls_rd_we;
    logic [`REG_ADDR_W-1:0] ls_rd_addr;
    logic [`XLEN-1:0]       ls_rd_data;

    modport src (
        output ex_rd_we, ex_rd_addr, ex_rd_data, ex_load,
        output ls_rd_we, ls_rd_addr, ls_rd_data
    );

    modport fwd (
        input ex_rd_we, ex_rd_addr, ex_rd_data, ex_load,
        input ls_rd_we, ls_rd_addr, ls_rd_data
    );
endinterface

`default_nettype wire

// ==== logic/idu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idu_defs.svh"

module idu_ctrl import rv_isa_pkg::*; import idu_pkg::*; (
    input  wire                 clk_i,
    input  wire                 arst_n_i,
    input  wire                 inst_valid_i,
    input  wire [`INST_W-1:0]   inst_i,
    input  wire [`XLEN-1:0]     pc_i,
    input  wire [`XLEN-1:0]     rs1_val_i,
    input  wire [`XLEN-1:0]     rs2_val_i,
    input  wire [`XLEN-1:0]     imm_i,
    input  wire                 taken_i,
    rf_fwd_if.fwd               fwd,
    output inst_class_e         inst_class_o,
    output alu_op_e             alu_op_o,
    output logic                rs1_re_o,
    output logic                rs2_re_o,
    output logic                stall_o,
    output logic                jump_req_o,
    output dec_bundle_t         bundle_o
);

    r_type_t     f;
    inst_class_e cls;
    alu_op_e     op;
    logic        rs1_hit;
    logic        rs2_hit;
    dec_bundle_t bundle_d;

    assign f = r_type_t'(inst_i); // register fields sit at the same spot in every format

    always_comb begin
        cls = CLS_NONE;
        op  = OP_ADD;
        case (f.opcode)
            OPC_OP: begin
                cls = CLS_R;
                case ({f.funct7, f.funct3})
                    {F7_BASE, F3_ADD_SUB}: op = OP_ADD;
                    {F7_ALT,  F3_ADD_SUB}: op = OP_SUB;
                    {F7_BASE, F3_SLL}:     op = OP_SLL;
                    {F7_BASE, F3_SLT}:     op = OP_SLT;
                    {F7_BASE, F3_SLTU}:    op = OP_SLTU;
                    {F7_BASE, F3_XOR}:     op = OP_XOR;
                    {F7_BASE, F3_SRL_SRA}: op = OP_SRL;
                    {F7_ALT,  F3_SRL_SRA}: op = OP_SRA;
                    {F7_BASE, F3_OR}:      op = OP_OR;
                    {F7_BASE, F3_AND}:     op = OP_AND;
                    default:               cls = CLS_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                cls = CLS_I;
                case (f.funct3)
                    F3_ADD_SUB: op = OP_ADD;
                    F3_SLL:     op = OP_SLL;
                    F3_SLT:     op = OP_SLT;
                    F3_SLTU:    op = OP_SLTU;
                    F3_XOR:     op = OP_XOR;
                    F3_OR:      op = OP_OR;
                    F3_AND:     op = OP_AND;
                    default:    op = (f.funct7 == F7_ALT) ? OP_SRA : OP_SRL;
                endcase
                // shift amount leaves funct7 in the upper immediate
                if (f.funct3 == F3_SLL && f.funct7 != F7_BASE)
                    cls = CLS_NONE;
                if (f.funct3 == F3_SRL_SRA && !(f.funct7 inside {F7_BASE, F7_ALT}))
                    cls = CLS_NONE;
            end
            OPC_LUI: begin
                cls = CLS_U;
                op  = OP_LUI;
            end
            OPC_AUIPC: begin
                cls = CLS_U;
                op  = OP_AUIPC;
            end
            OPC_LOAD: begin
                cls = CLS_L;
                case (f.funct3)
                    F3_LB:   op = OP_LB;
                    F3_LH:   op = OP_LH;
                    F3_LW:   op = OP_LW;
                    F3_LBU:  op = OP_LBU;
                    F3_LHU:  op = OP_LHU;
                    default: cls = CLS_NONE;
                endcase
            end
            OPC_STORE: begin
                cls = CLS_S;
                case (f.funct3)
                    F3_SB:   op = OP_SB;
                    F3_SH:   op = OP_SH;
                    F3_SW:   op = OP_SW;
                    default: cls = CLS_NONE;
                endcase
            end
            OPC_JAL: begin
                cls = CLS_J;
                op  = OP_JAL;
            end
            OPC_JALR: begin
                if (f.funct3 == F3_JALR) begin
                    cls = CLS_J;
                    op  = OP_JALR;
                end
            end
            OPC_BRANCH: begin
                cls = CLS_B;
                case (f.funct3)
                    F3_BEQ:  op = OP_BEQ;
                    F3_BNE:  op = OP_BNE;
                    F3_BLT:  op = OP_BLT;
                    F3_BGE:  op = OP_BGE;
                    F3_BLTU: op = OP_BLTU;
                    F3_BGEU: op = OP_BGEU;
                    default: cls = CLS_NONE;
                endcase
            end
            default: cls = CLS_NONE;
        endcase
    end

    assign inst_class_o = cls;
    assign alu_op_o     = op;
    assign rs1_re_o     = (cls inside {CLS_R, CLS_I, CLS_L, CLS_S, CLS_B}) || op == OP_JALR;
    assign rs2_re_o     = cls inside {CLS_R, CLS_S, CLS_B};

    // load-use, the loaded value is only ready in load/store
    assign rs1_hit    = rs1_re_o && f.rs1 != '0 && f.rs1 == fwd.ex_rd_addr;
    assign rs2_hit    = rs2_re_o && f.rs2 != '0 && f.rs2 == fwd.ex_rd_addr;
    assign stall_o    = inst_valid_i && fwd.ex_load && (rs1_hit || rs2_hit);
    assign jump_req_o = inst_valid_i && taken_i && !stall_o;

    always_comb begin
        bundle_d.valid      = inst_valid_i && !stall_o;
        bundle_d.pc         = pc_i;
        bundle_d.op1        = (cls inside {CLS_R, CLS_I, CLS_L, CLS_S}) ? rs1_val_i : '0;
        bundle_d.op2        = (cls inside {CLS_R, CLS_S}) ? rs2_val_i : '0;
        bundle_d.imm        = imm_i;
        bundle_d.rd_addr    = (cls inside {CLS_S, CLS_B}) ? '0 : f.rd;
        bundle_d.rd_we      = cls inside {CLS_R, CLS_I, CLS_U, CLS_J};
        bundle_d.inst_class = cls;
        bundle_d.alu_op     = op;
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bundle_o <= '0;
        end else if (bundle_d.valid) begin
            bundle_o <= bundle_d;
        end else begin
            bundle_o <= '0; // bubble into execute
        end
    end

    // only jal, jalr and branches redirect fetch
    a_jump_is_control: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        jump_req_o |-> cls inside {CLS_J, CLS_B});

    a_imm_only_with_field: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cls inside {CLS_R, CLS_J, CLS_B} |-> imm_i == '0);

endmodule

`default_nettype wire

// ==== logic/idu_imm_gen.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idu_defs.svh"

module idu_imm_gen import rv_isa_pkg::*; import idu_pkg::*; (
    input  wire [`INST_W-1:0]   inst_i,
    input  var  inst_class_e    inst_class_i,
    input  var  alu_op_e        alu_op_i,
    output logic [`XLEN-1:0]    imm_o,
    output logic [`XLEN-1:0]    br_imm_o    // jump and branch offset
);

    i_type_t          it;
    s_type_t          st;
    b_type_t          bt;
    u_type_t          ut;
    j_type_t          jt;
    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] s_imm;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] u_imm;
    logic [`XLEN-1:0] j_imm;

    assign it = i_type_t'(inst_i);
    assign st = s_type_t'(inst_i);
    assign bt = b_type_t'(inst_i);
    assign ut = u_type_t'(inst_i);
    assign jt = j_type_t'(inst_i);

    assign i_imm = {{(`XLEN-12){it.imm[11]}}, it.imm};
    assign s_imm = {{(`XLEN-12){st.imm_hi[6]}}, st.imm_hi, st.imm_lo};
    assign u_imm = {ut.imm, 12'b0}; // low bits zero filled
    assign b_imm = {{(`XLEN-13){bt.imm12}}, bt.imm12, bt.imm11, bt.imm10_5, bt.imm4_1, 1'b0};
    assign j_imm = {{(`XLEN-21){jt.imm20}}, jt.imm20, jt.imm19_12, jt.imm11, jt.imm10_1, 1'b0};

    always_comb begin
        case (inst_class_i)
            CLS_I, CLS_L: imm_o = i_imm;
            CLS_S:        imm_o = s_imm;
            CLS_U:        imm_o = u_imm;
            default:      imm_o = '0;
        endcase
        case (alu_op_i)
            OP_JAL:  br_imm_o = j_imm;
            OP_JALR: br_imm_o = i_imm;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: br_imm_o = b_imm;
            default: br_imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/idu_operand_fwd.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idu_defs.svh"

module idu_operand_fwd (
    input  wire [`REG_ADDR_W-1:0]   rs1_addr_i,
    input  wire [`REG_ADDR_W-1:0]   rs2_addr_i,
    input  wire [`XLEN-1:0]         rs1_data_i,
    input  wire [`XLEN-1:0]         rs2_data_i,
    rf_fwd_if.fwd                   fwd,
    output logic [`XLEN-1:0]        rs1_val_o,
    output logic [`XLEN-1:0]        rs2_val_o
);

    // youngest producer wins, x0 never forwarded
    function automatic logic [`XLEN-1:0] src_val(
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`XLEN-1:0]       rf_data
    );
        if (addr == '0) begin
            return rf_data;
        end else if (fwd.ex_rd_we && fwd.ex_rd_addr == addr) begin
            return fwd.ex_rd_data;
        end else if (fwd.ls_rd_we && fwd.ls_rd_addr == addr) begin
            return fwd.ls_rd_data;
        end
        return rf_data;
    endfunction

    always_comb begin
        rs1_val_o = src_val(rs1_addr_i, rs1_data_i);
        rs2_val_o = src_val(rs2_addr_i, rs2_data_i);
    end

endmodule

`default_nettype wire

// ==== logic/idu_branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idu_defs.svh"

module idu_branch_unit import idu_pkg::*; (
    input  var  alu_op_e        alu_op_i,
    input  wire [`XLEN-1:0]     pc_i,
    input  wire [`XLEN-1:0]     rs1_val_i,  // already forwarded
    input  wire [`XLEN-1:0]     rs2_val_i,
    input  wire [`XLEN-1:0]     br_imm_i,
    output logic                taken_o,
    output logic [`XLEN-1:0]    target_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    assign eq   = rs1_val_i == rs2_val_i;
    assign lt_s = $signed(rs1_val_i) < $signed(rs2_val_i);
    assign lt_u = rs1_val_i < rs2_val_i;

    always_comb begin
        case (alu_op_i)
            OP_JAL, OP_JALR: taken_o = 1'b1;
            OP_BEQ:          taken_o = eq;
            OP_BNE:          taken_o = !eq;
            OP_BLT:          taken_o = lt_s;
            OP_BGE:          taken_o = !lt_s;
            OP_BLTU:         taken_o = lt_u;
            OP_BGEU:         taken_o = !lt_u;
            default:         taken_o = 1'b0;
        endcase
    end

    assign target_o = (alu_op_i == OP_JALR) ? rs1_val_i + br_imm_i : pc_i + br_imm_i;

    // pc relative targets stay aligned as long as fetch hands in an aligned pc
    a_target_aligned: assert final (!(taken_o && alu_op_i != OP_JALR) || !target_o[0]);

endmodule

`default_nettype wire

// ==== logic/rv32_idu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idu_defs.svh"

module rv32_idu import idu_pkg::*; (
    input  wire                     clk_i,
    input  wire                     arst_n_i,
    input  wire                     inst_valid_i,
    input  wire [`INST_W-1:0]       inst_i,
    input  wire [`XLEN-1:0]         pc_i,
    input  wire [`XLEN-1:0]         rs1_data_i,
    input  wire [`XLEN-1:0]         rs2_data_i,
    input  wire                     ex_rd_we_i,
    input  wire [`REG_ADDR_W-1:0]   ex_rd_addr_i,
    input  wire [`XLEN-1:0]         ex_rd_data_i,
    input  wire                     ex_load_i,
    input  wire                     ls_rd_we_i,
    input  wire [`REG_ADDR_W-1:0]   ls_rd_addr_i,
    input  wire [`XLEN-1:0]         ls_rd_data_i,
    output logic [`REG_ADDR_W-1:0]  rs1_addr_o,
    output logic                    rs1_re_o,
    output logic [`REG_ADDR_W-1:0]  rs2_addr_o,
    output logic                    rs2_re_o,
    output logic                    stall_o,
    output logic                    jump_req_o,
    output logic [`XLEN-1:0]        jump_pc_o,
    output logic                    valid_o,
    output logic [`XLEN-1:0]        pc_o,
    output logic [`XLEN-1:0]        op1_o,
    output logic [`XLEN-1:0]        op2_o,
    output logic [`XLEN-1:0]        imm_o,
    output logic [`REG_ADDR_W-1:0]  rd_addr_o,
    output logic                    rd_we_o,
    output inst_class_e             inst_class_o,
    output alu_op_e                 alu_op_o
);

    rf_fwd_if fwd_bus ();

    inst_class_e      dec_class;
    alu_op_e          dec_op;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] br_imm;
    logic             taken;
    dec_bundle_t      dec_q;

    assign fwd_bus.ex_rd_we   = ex_rd_we_i;
    assign fwd_bus.ex_rd_addr = ex_rd_addr_i;
    assign fwd_bus.ex_rd_data = ex_rd_data_i;
    assign fwd_bus.ex_load    = ex_load_i;
    assign fwd_bus.ls_rd_we   = ls_rd_we_i;
    assign fwd_bus.ls_rd_addr = ls_rd_addr_i;
    assign fwd_bus.ls_rd_data = ls_rd_data_i;

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    idu_ctrl u_ctrl (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .inst_valid_i (inst_valid_i),
        .inst_i       (inst_i),
        .pc_i         (pc_i),
        .rs1_val_i    (rs1_val),
        .rs2_val_i    (rs2_val),
        .imm_i        (imm),
        .taken_i      (taken),
        .fwd          (fwd_bus),
        .inst_class_o (dec_class),
        .alu_op_o     (dec_op),
        .rs1_re_o     (rs1_re_o),
        .rs2_re_o     (rs2_re_o),
        .stall_o      (stall_o),
        .jump_req_o   (jump_req_o),
        .bundle_o     (dec_q)
    );

    idu_imm_gen u_imm_gen (
        .inst_i       (inst_i),
        .inst_class_i (dec_class),
        .alu_op_i     (dec_op),
        .imm_o        (imm),
        .br_imm_o     (br_imm)
    );

    idu_operand_fwd u_operand_fwd (
        .rs1_addr_i (rs1_addr_o),
        .rs2_addr_i (rs2_addr_o),
        .rs1_data_i (rs1_data_i),
        .rs2_data_i (rs2_data_i),
        .fwd        (fwd_bus),
        .rs1_val_o  (rs1_val),
        .rs2_val_o  (rs2_val)
    );

    idu_branch_unit u_branch_unit (
        .alu_op_i  (dec_op),
        .pc_i      (pc_i),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .br_imm_i  (br_imm),
        .taken_o   (taken),
        .target_o  (jump_pc_o)
    );

    // registered bundle out to execute
    assign valid_o      = dec_q.valid;
    assign pc_o         = dec_q.pc;
    assign op1_o        = dec_q.op1;
    assign op2_o        = dec_q.op2;
    assign imm_o        = dec_q.imm;
    assign rd_addr_o    = dec_q.rd_addr;
    assign rd_we_o      = dec_q.rd_we;
    assign inst_class_o = dec_q.inst_class;
    assign alu_op_o     = dec_q.alu_op;

endmodule

`default_nettype wire

// ==== dv/idu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "idu_defs.svh"

module idu_tb import idu_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    logic                   clk_i;
    logic                   arst_n_i;
    logic                   inst_valid_i;
    logic [`INST_W-1:0]     inst_i;
    logic [`XLEN-1:0]       pc_i;
    logic [`XLEN-1:0]       rs1_data_i;
    logic [`XLEN-1:0]       rs2_data_i;
    logic                   ex_rd_we_i;
    logic [`REG_ADDR_W-1:0] ex_rd_addr_i;
    logic [`XLEN-1:0]       ex_rd_data_i;
    logic                   ex_load_i;
    logic                   ls_rd_we_i;
    logic [`REG_ADDR_W-1:0] ls_rd_addr_i;
    logic [`XLEN-1:0]       ls_rd_data_i;
    logic [`REG_ADDR_W-1:0] rs1_addr_o;
    logic                   rs1_re_o;
    logic [`REG_ADDR_W-1:0] rs2_addr_o;
    logic                   rs2_re_o;
    logic                   stall_o;
    logic                   jump_req_o;
    logic [`XLEN-1:0]       jump_pc_o;
    logic                   valid_o;
    logic [`XLEN-1:0]       pc_o;
    logic [`XLEN-1:0]       op1_o;
    logic [`XLEN-1:0]       op2_o;
    logic [`XLEN-1:0]       imm_o;
    logic [`REG_ADDR_W-1:0] rd_addr_o;
    logic                   rd_we_o;
    inst_class_e            inst_class_o;
    alu_op_e                alu_op_o;

    integer seed = 32'hbb788fb1;
    int     cycles = 0;
    int     errors = 0;
    int     errors_at_start;
    int     tests_ok = 0;
    int     tests_bad = 0;
    string  cur_test;

    rv32_idu UUT (.*);

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // condition from the isa rules, f3 selects the compare
    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("[ERROR] %s %s: expected %h, actual %h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            $display("%s: ok", cur_test);
            tests_ok++;
        end else begin
            $display("%s: %0d mismatches", cur_test, errors - errors_at_start);
            tests_bad++;
        end
    endtask

    task automatic clear_fwd();
        ex_rd_we_i   = 1'b0;
        ex_rd_addr_i = '0;
        ex_rd_data_i = '0;
        ex_load_i    = 1'b0;
        ls_rd_we_i   = 1'b0;
        ls_rd_addr_i = '0;
        ls_rd_data_i = '0;
    endtask

    // called at drive time, leaves combinational outputs settled
    task automatic apply_inst(input logic [31:0] inst, input logic [31:0] pc,
                              input logic [31:0] a, input logic [31:0] b);
        inst_valid_i = 1'b1;
        inst_i       = inst;
        pc_i         = pc;
        rs1_data_i   = a;
        rs2_data_i   = b;
        #5;
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #2;
    endtask

    task automatic check_bundle(input logic [31:0] pc, input inst_class_e cls,
                                input alu_op_e op, input logic [4:0] rd, input logic we,
                                input logic [31:0] op1, input logic [31:0] op2,
                                input logic [31:0] imm);
        check_val("valid_o", 1, valid_o);
        check_val("pc_o", pc, pc_o);
        check_val("inst_class_o", cls, inst_class_o);
        check_val("alu_op_o", op, alu_op_o);
        check_val("rd_addr_o", rd, rd_addr_o);
        check_val("rd_we_o", we, rd_we_o);
        check_val("op1_o", op1, op1_o);
        check_val("op2_o", op2, op2_o);
        check_val("imm_o", imm, imm_o);
    endtask

    task automatic run_r_op(input logic [6:0] f7, input logic [2:0] f3, input alu_op_e op);
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  rd;
        a  = $random(seed);
        b  = $random(seed);
        rd = {$random(seed)} % 31 + 1;
        apply_inst(enc_r(f7, 5'd6, 5'd5, f3, rd), 32'h200, a, b);
        check_val("rs1_addr_o", 5, rs1_addr_o);
        check_val("rs2_addr_o", 6, rs2_addr_o);
        check_val("rs1_re_o", 1, rs1_re_o);
        check_val("rs2_re_o", 1, rs2_re_o);
        check_val("stall_o", 0, stall_o);
        next_cycle();
        check_bundle(32'h200, CLS_R, op, rd, 1'b1, a, b, 0);
    endtask

    task automatic run_i_op(input logic [2:0] f3, input logic [11:0] imm, input alu_op_e op);
        logic [31:0] a;
        logic [4:0]  rd;
        a  = $random(seed);
        rd = {$random(seed)} % 31 + 1;
        apply_inst(enc_i(imm, 5'd7, f3, rd, OPC_OP_IMM), 32'h300, a, $random(seed));
        check_val("rs1_re_o", 1, rs1_re_o);
        check_val("rs2_re_o", 0, rs2_re_o);
        next_cycle();
        check_bundle(32'h300, CLS_I, op, rd, 1'b1, a, 0, {{20{imm[11]}}, imm});
    endtask

    task automatic test_reset();
        start_test("reset");
        check_val("valid_o in reset", 0, valid_o);
        @(posedge clk_i);
        #2;
        arst_n_i = 1'b1;
        #5;
        check_val("valid_o", 0, valid_o);
        check_val("rd_we_o", 0, rd_we_o);
        check_val("jump_req_o", 0, jump_req_o);
        next_cycle();
        finish_test();
    endtask

    task automatic test_alu();
        logic [11:0] imm;
        start_test("alu");
        clear_fwd();
        run_r_op(7'b0000000, 3'b000, OP_ADD);
        run_r_op(7'b0100000, 3'b000, OP_SUB);
        run_r_op(7'b0000000, 3'b001, OP_SLL);
        run_r_op(7'b0000000, 3'b010, OP_SLT);
        run_r_op(7'b0000000, 3'b011, OP_SLTU);
        run_r_op(7'b0000000, 3'b100, OP_XOR);
        run_r_op(7'b0000000, 3'b101, OP_SRL);
        run_r_op(7'b0100000, 3'b101, OP_SRA);
        run_r_op(7'b0000000, 3'b110, OP_OR);
        run_r_op(7'b0000000, 3'b111, OP_AND);
        imm = $random(seed);
        run_i_op(3'b000, imm, OP_ADD);
        run_i_op(3'b010, 12'hf80, OP_SLT);
        run_i_op(3'b011, 12'h7ff, OP_SLTU);
        imm = $random(seed);
        run_i_op(3'b100, imm, OP_XOR);
        run_i_op(3'b110, 12'h800, OP_OR);
        run_i_op(3'b111, 12'h0ff, OP_AND);
        run_i_op(3'b001, 12'h01f, OP_SLL);
        run_i_op(3'b101, 12'h003, OP_SRL);
        run_i_op(3'b101, 12'h40a, OP_SRA); // funct7 of sra in the upper immediate
        finish_test();
    endtask

    task automatic test_mem();
        logic [31:0] a;
        logic [31:0] b;
        logic [19:0] up;
        start_test("lui auipc load store");
        clear_fwd();
        a  = $random(seed);
        b  = $random(seed);
        up = $random(seed);
        apply_inst({up, 5'd3, OPC_LUI}, 32'h400, a, b);
        next_cycle();
        check_bundle(32'h400, CLS_U, OP_LUI, 3, 1'b1, 0, 0, {up, 12'h000});
        apply_inst({up ^ 20'h8_0001, 5'd4, OPC_AUIPC}, 32'h404, a, b);
        next_cycle();
        check_bundle(32'h404, CLS_U, OP_AUIPC, 4, 1'b1, 0, 0, {up ^ 20'h8_0001, 12'h000});
        apply_inst(enc_i(12'hff8, 5'd2, 3'b010, 5'd9, OPC_LOAD), 32'h408, a, b);
        check_val("rs1_re_o", 1, rs1_re_o);
        next_cycle();
        check_bundle(32'h408, CLS_L, OP_LW, 9, 1'b0, a, 0, 32'hffff_fff8);
        apply_inst(enc_s(12'h8a5, 5'd11, 5'd2, 3'b010), 32'h40c, a, b);
        check_val("rs2_re_o", 1, rs2_re_o);
        next_cycle();
        check_bundle(32'h40c, CLS_S, OP_SW, 0, 1'b0, a, b, 32'hffff_f8a5);
        finish_test();
    endtask

    task automatic test_fwd();
        logic [31:0] rf;
        logic [31:0] b;
        start_test("forwarding");
        rf = $random(seed);
        b  = $random(seed);
        clear_fwd();
        ex_rd_we_i   = 1'b1;
        ex_rd_addr_i = 5'd5;
        ex_rd_data_i = $random(seed);
        ls_rd_we_i   = 1'b1;
        ls_rd_addr_i = 5'd5;
        ls_rd_data_i = $random(seed);
        apply_inst(enc_r(7'b0, 5'd6, 5'd5, 3'b000, 5'd1), 32'h500, rf, b);
        next_cycle();
        check_val("op1_o from execute", ex_rd_data_i, op1_o);
        check_val("op2_o from regfile", b, op2_o);
        ex_rd_we_i = 1'b0; // execute still names x5 but does not write
        apply_inst(enc_r(7'b0, 5'd6, 5'd5, 3'b000, 5'd1), 32'h504, rf, b);
        next_cycle();
        check_val("op1_o from load/store", ls_rd_data_i, op1_o);
        ex_rd_we_i   = 1'b1;
        ex_rd_addr_i = 5'd0;
        ls_rd_addr_i = 5'd0;
        apply_inst(enc_r(7'b0, 5'd6, 5'd0, 3'b000, 5'd1), 32'h508, rf, b);
        next_cycle();
        check_val("op1_o for x0", rf, op1_o);
        clear_fwd();
        finish_test();
    endtask

    task automatic test_load_use();
        logic [31:0] b;
        start_test("load use");
        b = $random(seed);
        clear_fwd();
        ex_load_i    = 1'b1;
        ex_rd_we_i   = 1'b1;
        ex_rd_addr_i = 5'd5;
        ex_rd_data_i = b; // branch would be taken without the stall
        apply_inst(enc_b(13'h010, 5'd6, 5'd5, 3'b000), 32'h600, $random(seed), b);
        check_val("stall_o", 1, stall_o);
        check_val("jump_req_o", 0, jump_req_o);
        next_cycle();
        check_val("valid_o bubble", 0, valid_o);
        ex_rd_addr_i = 5'd0;
        apply_inst(enc_r(7'b0, 5'd6, 5'd0, 3'b000, 5'd1), 32'h604, 0, b);
        check_val("stall_o for x0", 0, stall_o);
        next_cycle();
        check_val("valid_o", 1, valid_o);
        clear_fwd();
        finish_test();
    endtask

    task automatic run_branch(input logic [2:0] f3, input alu_op_e op);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pc;
        logic [12:0] off;
        for (int i = 0; i < 8; i++) begin
            a   = $random(seed);
            b   = (i % 3 == 0) ? a : $random(seed);
            pc  = $random(seed) & 32'hffff_fffc;
            off = $random(seed) & 13'h1ffe;
            apply_inst(enc_b(off, 5'd6, 5'd5, f3), pc, a, b);
            check_val("jump_req_o", branch_taken(f3, a, b), jump_req_o);
            check_val("jump_pc_o", pc + {{19{off[12]}}, off}, jump_pc_o);
            next_cycle();
            check_val("inst_class_o", CLS_B, inst_class_o);
            check_val("alu_op_o", op, alu_op_o);
        end
    endtask

    task automatic test_branch();
        logic [31:0] a;
        logic [31:0] pc;
        logic [20:0] joff;
        logic [11:0] imm;
        start_test("branch and jump");
        clear_fwd();
        run_branch(3'b000, OP_BEQ);
        run_branch(3'b001, OP_BNE);
        run_branch(3'b100, OP_BLT);
        run_branch(3'b101, OP_BGE);
        run_branch(3'b110, OP_BLTU);
        run_branch(3'b111, OP_BGEU);
        pc   = $random(seed) & 32'hffff_fffc;
        joff = $random(seed) & 21'h1f_fffe;
        apply_inst(enc_j(joff, 5'd1), pc, $random(seed), 0);
        check_val("jal jump_req_o", 1, jump_req_o);
        check_val("jal jump_pc_o", pc + {{11{joff[20]}}, joff}, jump_pc_o);
        next_cycle();
        a   = $random(seed);
        imm = $random(seed);
        apply_inst(enc_i(imm, 5'd5, 3'b000, 5'd1, OPC_JALR), pc, a, 0);
        check_val("jalr jump_req_o", 1, jump_req_o);
        check_val("jalr jump_pc_o", a + {{20{imm[11]}}, imm}, jump_pc_o);
        next_cycle();
        inst_valid_i = 1'b0;
        finish_test();
    endtask

    initial begin
        clk_i        = 1'b0;
        arst_n_i     = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        pc_i         = '0;
        rs1_data_i   = '0;
        rs2_data_i   = '0;
        clear_fwd();
        repeat (4) @(posedge clk_i);
        test_reset();
        test_alu();
        test_mem();
        test_fwd();
        test_load_use();
        test_branch();
        $display("tests: %0d clean, %0d with mismatches", tests_ok, tests_bad);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== idu.f ====
+incdir+logic
logic/rv_isa_pkg.sv
logic/idu_pkg.sv
logic/rf_fwd_if.sv
logic/idu_ctrl.sv
logic/idu_imm_gen.sv
logic/idu_operand_fwd.sv
logic/idu_branch_unit.sv
logic/rv32_idu.sv
dv/idu_tb.sv
